//--- list.f
src/cache_pkg.sv
src/way_if.sv
src/way_store.sv
src/icache_ctrl.sv
src/dcache_ctrl.sv
src/cache_pair.sv
verif/mem_model.sv
verif/tb_cache_pair.sv

//--- run.sh
#!/bin/sh
# build and run the cache pair testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module tb_cache_pair -o sim_cache_pair \
	|| { echo "build failed"; exit 1; }
./obj_dir/sim_cache_pair > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

//--- src/cache_pair.sv
// split instruction and data cache top
`timescale 1ns/1ps

module cache_pair (
	input  logic                  clk,
	input  logic                  proc_reset,

	// instruction fetch port
	input  logic                  i_read,
	input  cache_pkg::proc_addr_t i_addr,
	output cache_pkg::word_t      i_rdata,
	output logic                  i_stall,

	// instruction line memory
	output logic                  i_mem_read,
	output cache_pkg::line_addr_t i_mem_addr,
	input  cache_pkg::line_t      i_mem_rdata,
	input  logic                  i_mem_ready,

	// data port
	input  logic                  d_read,
	input  logic                  d_write,
	input  cache_pkg::proc_addr_t d_addr,
	input  cache_pkg::word_t      d_wdata,
	output cache_pkg::word_t      d_rdata,
	output logic                  d_stall,

	// data line memory
	output logic                  d_mem_read,
	output logic                  d_mem_write,
	output cache_pkg::line_addr_t d_mem_addr,
	output cache_pkg::line_t      d_mem_wdata,
	input  cache_pkg::line_t      d_mem_rdata,
	input  logic                  d_mem_ready
);

	way_if i_bus ();
	way_if d_bus ();

	// --------------------
	// instruction cache
	// --------------------
	icache_ctrl u_icache_ctrl (
		.clk        (clk),
		.proc_reset (proc_reset),
		.read       (i_read),
		.addr       (i_addr),
		.stall      (i_stall),
		.mem_read   (i_mem_read),
		.mem_addr   (i_mem_addr),
		.mem_rdata  (i_mem_rdata),
		.mem_ready  (i_mem_ready),
		.store      (i_bus)
	);

	way_store #(.has_dirty(1'b0)) u_icache_store (
		.clk        (clk),
		.proc_reset (proc_reset),
		.bus        (i_bus)
	);

	assign i_rdata = i_bus.rdata;  // valid whenever stall is low

	// --------------------
	// data cache
	// --------------------
	dcache_ctrl u_dcache_ctrl (
		.clk        (clk),
		.proc_reset (proc_reset),
		.read       (d_read),
		.write      (d_write),
		.addr       (d_addr),
		.wdata      (d_wdata),
		.stall      (d_stall),
		.mem_read   (d_mem_read),
		.mem_write  (d_mem_write),
		.mem_addr   (d_mem_addr),
		.mem_wdata  (d_mem_wdata),
		.mem_rdata  (d_mem_rdata),
		.mem_ready  (d_mem_ready),
		.store      (d_bus)
	);

	way_store #(.has_dirty(1'b1)) u_dcache_store (
		.clk        (clk),
		.proc_reset (proc_reset),
		.bus        (d_bus)
	);

	assign d_rdata = d_bus.rdata;

endmodule

//--- src/cache_pkg.sv
// cache pair shared definitions
package cache_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int WORD_W      = 32;
	localparam int LINE_W      = 128;  // four words per line
	localparam int ADDR_W      = 30;   // word address from the processor
	localparam int TAG_W       = 26;
	localparam int SET_W       = 2;
	localparam int OFS_W       = 2;
	localparam int SETS        = 4;
	localparam int LINE_ADDR_W = 28;   // tag followed by set

	// --------------------
	// data and address types
	// --------------------
	typedef logic [WORD_W-1:0]      word_t;
	typedef logic [LINE_W-1:0]      line_t;
	typedef logic [ADDR_W-1:0]      proc_addr_t;
	typedef logic [TAG_W-1:0]       tag_t;
	typedef logic [SET_W-1:0]       set_t;
	typedef logic [OFS_W-1:0]       ofs_t;
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;

	// processor address layout
	//   [29:4] tag
	//   [3:2]  set
	//   [1:0]  word within the line

	// --------------------
	// miss controller states
	// --------------------
	// the instruction cache never enters write-back
	typedef enum logic [1:0] {
		st_compare    = 2'b00,  // lookup, serve hits
		st_write_back = 2'b01,  // dirty victim out to memory
		st_allocate   = 2'b10   // line refill from memory
	} ctrl_state_e;

endpackage

//--- src/dcache_ctrl.sv
// data cache write-back miss controller
`timescale 1ns/1ps

module dcache_ctrl (
	input  logic                  clk,
	input  logic                  proc_reset,
	input  logic                  read,
	input  logic                  write,
	input  cache_pkg::proc_addr_t addr,
	input  cache_pkg::word_t      wdata,
	output logic                  stall,
	output logic                  mem_read,
	output logic                  mem_write,
	output cache_pkg::line_addr_t mem_addr,
	output cache_pkg::line_t      mem_wdata,
	input  cache_pkg::line_t      mem_rdata,
	input  logic                  mem_ready,
	way_if.ctrl                   store
);

	cache_pkg::ctrl_state_e state_q;
	cache_pkg::ctrl_state_e state_d;
	logic                   req;
	logic                   miss;
	logic                   in_compare;

	assign req        = read || write;
	assign miss       = req && !store.hit;
	assign in_compare = (state_q == cache_pkg::st_compare);

	// --------------------
	// next state
	// --------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_pkg::st_compare: begin
				if (miss) begin
					// modified victim has to leave first
					if (store.victim_dirty) begin
						state_d = cache_pkg::st_write_back;
					end else begin
						state_d = cache_pkg::st_allocate;
					end
				end
			end
			cache_pkg::st_write_back: begin
				if (mem_ready) begin
					state_d = cache_pkg::st_allocate;
				end
			end
			cache_pkg::st_allocate: begin
				if (mem_ready) begin
					state_d = cache_pkg::st_compare;
				end
			end
			default: state_d = cache_pkg::st_compare;
		endcase
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= cache_pkg::st_compare;
		end else begin
			state_q <= state_d;
		end
	end

	// --------------------
	// memory side
	// --------------------
	assign mem_read  = (state_q == cache_pkg::st_allocate);
	assign mem_write = (state_q == cache_pkg::st_write_back);

	// victim line address during write-back, own line otherwise
	always_comb begin
		if (mem_write) begin
			mem_addr = store.victim_addr;
		end else begin
			mem_addr = addr[cache_pkg::ADDR_W-1:cache_pkg::OFS_W];
		end
	end

	assign mem_wdata = store.victim_line;  // stable while victim bit holds

	// processor side
	assign stall = in_compare ? miss : 1'b1;

	assign store.addr      = addr;
	assign store.fill      = mem_read && mem_ready;
	assign store.fill_line = mem_rdata;
	assign store.write     = in_compare && write && store.hit;  // sets dirty
	assign store.wdata     = wdata;

endmodule

//--- src/icache_ctrl.sv
// instruction cache miss controller
`timescale 1ns/1ps

module icache_ctrl (
	input  logic                  clk,
	input  logic                  proc_reset,
	input  logic                  read,
	input  cache_pkg::proc_addr_t addr,
	output logic                  stall,
	output logic                  mem_read,
	output cache_pkg::line_addr_t mem_addr,
	input  cache_pkg::line_t      mem_rdata,
	input  logic                  mem_ready,
	way_if.ctrl                   store
);

	cache_pkg::ctrl_state_e state_q;
	cache_pkg::ctrl_state_e state_d;
	logic                   miss;

	assign miss = read && !store.hit;

	// --------------------
	// next state
	// --------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_pkg::st_compare: begin
				if (miss) begin
					state_d = cache_pkg::st_allocate;
				end
			end
			cache_pkg::st_allocate: begin
				if (mem_ready) begin
					state_d = cache_pkg::st_compare;  // retry, hits now
				end
			end
			default: state_d = cache_pkg::st_compare;
		endcase
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= cache_pkg::st_compare;
		end else begin
			state_q <= state_d;
		end
	end

	// outputs
	assign stall    = (state_q == cache_pkg::st_compare) ? miss : 1'b1;
	assign mem_read = (state_q == cache_pkg::st_allocate);  // held through ready
	assign mem_addr = addr[cache_pkg::ADDR_W-1:cache_pkg::OFS_W];

	assign store.addr      = addr;
	assign store.fill      = mem_read && mem_ready;
	assign store.fill_line = mem_rdata;
	assign store.write     = 1'b0;  // read-only
	assign store.wdata     = '0;

endmodule

//--- src/way_if.sv
// controller to way store link
`timescale 1ns/1ps

interface way_if;

	// request side, driven by the miss controller
	cache_pkg::proc_addr_t addr;       // current processor address
	logic                  fill;       // refill strobe, one cycle
	cache_pkg::line_t      fill_line;  // line returned by memory
	logic                  write;      // word write on a hit
	cache_pkg::word_t      wdata;

	// lookup results, driven by the store
	logic                  hit;
	cache_pkg::word_t      rdata;         // addressed word of the hitting way
	logic                  victim_dirty;  // victim valid and modified
	cache_pkg::line_addr_t victim_addr;
	cache_pkg::line_t      victim_line;

	modport ctrl (
		output addr, fill, fill_line, write, wdata,
		input  hit, rdata, victim_dirty, victim_addr, victim_line
	);

	modport store (
		input  addr, fill, fill_line, write, wdata,
		output hit, rdata, victim_dirty, victim_addr, victim_line
	);

endinterface

//--- src/way_store.sv
// two-way set associative store
`timescale 1ns/1ps

module way_store #(
	parameter bit has_dirty = 1'b1  // 0 for a read-only cache
) (
	input  logic clk,
	input  logic proc_reset,
	way_if.store bus
);

	// --------------------
	// storage
	// --------------------
	// payload indexed [way][set]
	cache_pkg::tag_t  tag_mem  [2][cache_pkg::SETS];
	cache_pkg::line_t data_mem [2][cache_pkg::SETS];

	logic [1:0]                 valid_q [cache_pkg::SETS];  // one bit per way
	logic [cache_pkg::SETS-1:0] victim_q;                   // next way to replace

	// address fields
	cache_pkg::tag_t tag;
	cache_pkg::set_t set;
	cache_pkg::ofs_t ofs;

	logic [1:0]       way_hit;
	logic             hit_way;
	logic             vway;
	logic             wr_en;
	cache_pkg::line_t hit_line;

	assign tag = bus.addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
	assign set = bus.addr[cache_pkg::OFS_W +: cache_pkg::SET_W];
	assign ofs = bus.addr[cache_pkg::OFS_W-1:0];

	// --------------------
	// lookup
	// --------------------
	assign way_hit[0] = valid_q[set][0] && (tag_mem[0][set] == tag);
	assign way_hit[1] = valid_q[set][1] && (tag_mem[1][set] == tag);
	assign hit_way    = ~way_hit[0];  // way 0 wins, cannot both hit anyway

	assign hit_line  = data_mem[hit_way][set];
	assign bus.hit   = |way_hit;
	assign bus.rdata = hit_line[ofs*cache_pkg::WORD_W +: cache_pkg::WORD_W];

	// victim view for write-back
	assign vway            = victim_q[set];
	assign bus.victim_addr = {tag_mem[vway][set], set};
	assign bus.victim_line = data_mem[vway][set];

	assign wr_en = has_dirty && bus.write;  // read-only store drops writes

	// valid and replacement state
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < cache_pkg::SETS; s++) begin
				valid_q[s] <= '0;
			end
			victim_q <= '0;
		end else if (bus.fill) begin
			valid_q[set][vway] <= 1'b1;
			victim_q[set]      <= ~vway;  // round robin between the two ways
		end
	end

	// tags and lines
	always_ff @(posedge clk) begin
		if (bus.fill) begin
			tag_mem[vway][set]  <= tag;
			data_mem[vway][set] <= bus.fill_line;
		end else if (wr_en) begin
			data_mem[hit_way][set][ofs*cache_pkg::WORD_W +: cache_pkg::WORD_W] <= bus.wdata;
		end
	end

	// --------------------
	// dirty bits
	// --------------------
	generate
		if (has_dirty) begin : g_dirty
			logic [1:0] dirty_q [cache_pkg::SETS];

			always_ff @(posedge clk) begin
				if (proc_reset) begin
					for (int s = 0; s < cache_pkg::SETS; s++) begin
						dirty_q[s] <= '0;
					end
				end else if (bus.fill) begin
					dirty_q[set][vway] <= 1'b0;  // fresh line from memory
				end else if (wr_en) begin
					dirty_q[set][hit_way] <= 1'b1;
				end
			end

			assign bus.victim_dirty = valid_q[set][vway] && dirty_q[set][vway];
		end else begin : g_clean
			assign bus.victim_dirty = 1'b0;  // nothing ever modified
		end
	endgenerate

endmodule

//--- verif/mem_model.sv
// behavioural line memory
`timescale 1ns/1ps

module mem_model (
	input  logic                  clk,
	input  logic                  proc_reset,
	input  logic                  mem_read,
	input  logic                  mem_write,
	input  cache_pkg::line_addr_t mem_addr,
	input  cache_pkg::line_t      mem_wdata,
	output cache_pkg::line_t      mem_rdata,
	output logic                  mem_ready
);

	cache_pkg::line_t image [cache_pkg::line_addr_t];  // lines written back so far
	integer           seed;
	int               wait_cnt;
	logic             busy;

	// word k of an untouched line holds line address times 4 plus k
	function automatic cache_pkg::line_t line_at(input cache_pkg::line_addr_t la);
		cache_pkg::line_t l;
		if (image.exists(la)) begin
			return image[la];
		end
		for (int k = 0; k < 4; k++) begin
			l[k*cache_pkg::WORD_W +: cache_pkg::WORD_W] = cache_pkg::word_t'(la) * 4 + k;
		end
		return l;
	endfunction

	initial begin
		seed      = 37;
		busy      = 1'b0;
		wait_cnt  = 0;
		mem_ready = 1'b0;
		mem_rdata = '0;
	end

	// requests looked at just after the edge, once the cache outputs settle
	always @(posedge clk) begin
		#1;
		if (proc_reset) begin
			busy      = 1'b0;
			mem_ready = 1'b0;
		end else if (mem_ready) begin
			mem_ready = 1'b0;  // taken at this edge
			busy      = 1'b0;
		end else if (mem_read || mem_write) begin
			if (!busy) begin
				busy     = 1'b1;
				wait_cnt = $random(seed) & 3;  // ready in first to fourth cycle
			end
			if (wait_cnt == 0) begin
				if (mem_write) begin
					image[mem_addr] = mem_wdata;
				end else begin
					mem_rdata = line_at(mem_addr);
				end
				mem_ready = 1'b1;
			end else begin
				wait_cnt = wait_cnt - 1;
			end
		end
	end

endmodule

//--- verif/tb_cache_pair.sv
// cache pair testbench
`timescale 1ns/1ps

module tb_cache_pair;

	localparam int n_requests = 17;

	logic                  clk;
	logic                  proc_reset;
	logic                  i_read;
	cache_pkg::proc_addr_t i_addr;
	cache_pkg::word_t      i_rdata;
	logic                  i_stall;
	logic                  i_mem_read;
	cache_pkg::line_addr_t i_mem_addr;
	cache_pkg::line_t      i_mem_rdata;
	logic                  i_mem_ready;
	logic                  d_read;
	logic                  d_write;
	cache_pkg::proc_addr_t d_addr;
	cache_pkg::word_t      d_wdata;
	cache_pkg::word_t      d_rdata;
	logic                  d_stall;
	logic                  d_mem_read;
	logic                  d_mem_write;
	cache_pkg::line_addr_t d_mem_addr;
	cache_pkg::line_t      d_mem_wdata;
	cache_pkg::line_t      d_mem_rdata;
	logic                  d_mem_ready;

	cache_pkg::word_t      exp_mem [cache_pkg::proc_addr_t];  // data words written so far
	byte                   kind_log [$];  // I fill, R refill, W write-back
	cache_pkg::line_addr_t addr_log [$];
	cache_pkg::line_t      line_log [$];

	cache_pair DUT (.*);

	mem_model u_imem (
		.clk        (clk),
		.proc_reset (proc_reset),
		.mem_read   (i_mem_read),
		.mem_write  (1'b0),
		.mem_addr   (i_mem_addr),
		.mem_wdata  ('0),
		.mem_rdata  (i_mem_rdata),
		.mem_ready  (i_mem_ready)
	);

	mem_model u_dmem (
		.clk        (clk),
		.proc_reset (proc_reset),
		.mem_read   (d_mem_read),
		.mem_write  (d_mem_write),
		.mem_addr   (d_mem_addr),
		.mem_wdata  (d_mem_wdata),
		.mem_rdata  (d_mem_rdata),
		.mem_ready  (d_mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------
	// helpers
	// --------------------
	task automatic stop_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got === want) else begin
			$display("ERR %s expected 0x%08h got 0x%08h", name, want, got);
			stop_run();
		end
	endtask

	function automatic cache_pkg::word_t expected_word(input bit dside,
			input cache_pkg::proc_addr_t a);
		if (dside && exp_mem.exists(a)) begin
			return exp_mem[a];
		end
		return cache_pkg::word_t'(a[29:2]) * 4 + cache_pkg::word_t'(a[1:0]);
	endfunction

	function automatic cache_pkg::proc_addr_t make_addr(input int tag, input int set, input int ofs);
		return {26'(tag), 2'(set), 2'(ofs)};
	endfunction

	function automatic bit log_matches(input string want);
		if (kind_log.size() != want.len()) begin
			return 1'b0;
		end
		for (int i = 0; i < want.len(); i++) begin
			if (kind_log[i] != want[i]) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic note_transfer(input byte kind, input cache_pkg::line_addr_t la,
			input cache_pkg::line_t l);
		kind_log.push_back(kind);
		addr_log.push_back(la);
		line_log.push_back(l);
	endtask

	// memory transfers sampled mid cycle
	always @(negedge clk) begin
		if (!proc_reset) begin  // idle through reset
			assert (!(d_mem_read && d_mem_write)) else begin
				$display("d_mem_read and d_mem_write were high in the same cycle");
				stop_run();
			end
			if (i_mem_read && i_mem_ready) begin
				note_transfer("I", i_mem_addr, '0);
			end
			if (d_mem_write && d_mem_ready) begin
				note_transfer("W", d_mem_addr, d_mem_wdata);
			end
			if (d_mem_read && d_mem_ready) begin
				note_transfer("R", d_mem_addr, '0);
			end
		end
	end

	// one processor request held until stall falls
	task automatic access(input bit dside, input bit wr, input cache_pkg::proc_addr_t a,
			input cache_pkg::word_t wd, input string want_log);
		logic stall_now;
		kind_log.delete();
		addr_log.delete();
		line_log.delete();
		if (dside) begin
			d_read  = !wr;
			d_write = wr;
			d_addr  = a;
			d_wdata = wd;
		end else begin
			i_read = 1'b1;
			i_addr = a;
		end
		@(negedge clk);
		stall_now = dside ? d_stall : i_stall;
		expect_eq(dside ? "d_stall" : "i_stall", 32'(stall_now), 32'(want_log.len() != 0));
		if (want_log.len() == 0) begin
			expect_eq(dside ? "d_mem_read" : "i_mem_read",
				32'(dside ? d_mem_read : i_mem_read), 32'd0);
		end
		while (stall_now) begin
			@(negedge clk);
			stall_now = dside ? d_stall : i_stall;
		end
		if (wr) begin
			exp_mem[a] = wd;  // write lands at the next edge
		end else begin
			expect_eq(dside ? "d_rdata" : "i_rdata", dside ? d_rdata : i_rdata,
				expected_word(dside, a));
		end
		@(posedge clk);
		#2;
		i_read  = 1'b0;
		d_read  = 1'b0;
		d_write = 1'b0;
		assert (log_matches(want_log)) else begin
			$display("memory transfers differ from the expected sequence '%s'", want_log);
			stop_run();
		end
		foreach (kind_log[k]) begin
			if (kind_log[k] != "W") begin
				expect_eq(dside ? "d_mem_addr" : "i_mem_addr", 32'(addr_log[k]), 32'(a[29:2]));
			end
		end
	endtask

	// a write-back miss stays well under 20 cycles
	initial begin
		repeat ((n_requests + 2) * 20) @(posedge clk);
		$display("watchdog expired before all requests finished");
		stop_run();
	end

	// --------------------
	// stimulus
	// --------------------
	initial begin
		proc_reset = 1'b1;
		i_read     = 1'b0;
		i_addr     = '0;
		d_read     = 1'b0;
		d_write    = 1'b0;
		d_addr     = '0;
		d_wdata    = '0;
		repeat (3) @(posedge clk);
		#2;
		proc_reset = 1'b0;

		@(negedge clk);  // quiet out of reset
		expect_eq("i_stall", 32'(i_stall), 32'd0);
		expect_eq("d_stall", 32'(d_stall), 32'd0);
		expect_eq("i_mem_read", 32'(i_mem_read), 32'd0);
		expect_eq("d_mem_read", 32'(d_mem_read), 32'd0);
		expect_eq("d_mem_write", 32'(d_mem_write), 32'd0);
		@(posedge clk);
		#2;

		// instruction fill followed by every word of that line
		access(1'b0, 1'b0, make_addr(5, 1, 2), '0, "I");
		for (int k = 0; k < 4; k++) begin
			access(1'b0, 1'b0, make_addr(5, 1, k), '0, "");
		end
		access(1'b0, 1'b0, make_addr(9, 1, 0), '0, "I");
		access(1'b0, 1'b0, make_addr(13, 1, 3), '0, "I");  // third tag pushes out tag 5
		access(1'b0, 1'b0, make_addr(5, 1, 2), '0, "I");
		access(1'b0, 1'b0, make_addr(13, 1, 1), '0, "");

		// write allocate and read back
		access(1'b1, 1'b1, make_addr(2, 0, 1), 32'hcafe_0001, "R");
		access(1'b1, 1'b0, make_addr(2, 0, 1), '0, "");
		access(1'b1, 1'b0, make_addr(2, 0, 3), '0, "");

		// other way filled before the dirty line goes out first
		access(1'b1, 1'b0, make_addr(6, 0, 0), '0, "R");
		access(1'b1, 1'b0, make_addr(10, 0, 2), '0, "WR");
		expect_eq("d_mem_addr", 32'(addr_log[0]), 32'({26'd2, 2'd0}));
		expect_eq("d_mem_wdata", line_log[0][32 +: 32], 32'hcafe_0001);
		expect_eq("d_mem_wdata", line_log[0][96 +: 32], expected_word(1'b1, make_addr(2, 0, 3)));

		// clean victim leaves without a write-back
		access(1'b1, 1'b0, make_addr(2, 0, 1), '0, "R");
		access(1'b1, 1'b1, make_addr(10, 0, 0), 32'h5eed_0010, "");
		access(1'b1, 1'b0, make_addr(10, 0, 0), '0, "");

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
